//--- design/fetch_pkg.sv
package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // L0 prefetch buffer
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    EMPTY,        // Nothing fetched, waiting for first branch
    VALID_L0,     // Serving words from the stored line
    WAIT_GNT,     // Request pending, no grant yet
    WAIT_RVALID,  // Granted, line in flight
    WAIT_ABORTED  // Branch hit an in-flight line, drop it on arrival
  } l0_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction aligner
  ////////////////////////////////////////////////////////////////////////////

  // Where the next instruction starts relative to the current fetch word
  typedef enum logic [1:0] {
    ALIGNED,   // Low halfword
    HALF,      // Upper halfword
    STRADDLE   // 32-bit instr, upper half lives in next word
  } align_state_e;

  // One fetch word or one expanded instruction
  typedef logic [31:0] instr_word_t;

endpackage

//--- design/wb_pkg.sv
package wb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone classic read master
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    WB_IDLE,  // Bus free, cyc/stb low
    WB_BUSY   // Cycle open, waiting for ack
  } wb_state_e;

  // Byte address of an instruction line
  // Offset bits inside the line go out as zero
  typedef logic [31:0] line_addr_t;

endpackage

//--- design/wb_line_master.sv
`timescale 1ns/1ns

module wb_line_master #(
  parameter int LINE_WIDTH = 128
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Request side, from the prefetch buffer
  input  logic                   req_i,
  input  wb_pkg::line_addr_t     addr_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [LINE_WIDTH-1:0]  rdata_o,

  // Wishbone classic, read only
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output wb_pkg::line_addr_t     wb_adr_o,
  input  logic [LINE_WIDTH-1:0]  wb_dat_i,
  input  logic                   wb_ack_i
);

  localparam int OFFSET_BITS = $clog2(LINE_WIDTH / 8);  // Byte offset within a line

  wb_pkg::wb_state_e  state_q, state_d;
  wb_pkg::line_addr_t adr_q;
  wb_pkg::line_addr_t line_adr;   // Request address, offset cleared

  // Free bus, or the running cycle ends this very cycle
  assign gnt_o = req_i & ((state_q == wb_pkg::WB_IDLE) |
                          ((state_q == wb_pkg::WB_BUSY) & wb_ack_i));

  // Data goes straight through in the ack cycle
  assign rvalid_o = (state_q == wb_pkg::WB_BUSY) & wb_ack_i;
  assign rdata_o  = wb_dat_i;

  assign wb_cyc_o = (state_q == wb_pkg::WB_BUSY);
  assign wb_stb_o = (state_q == wb_pkg::WB_BUSY);  // Single transfer per cycle
  assign wb_adr_o = adr_q;

  always_comb
  begin
    line_adr                  = addr_i;
    line_adr[OFFSET_BITS-1:0] = '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus cycle FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      wb_pkg::WB_IDLE:
      begin
        if (gnt_o)
          state_d = wb_pkg::WB_BUSY;
      end
      wb_pkg::WB_BUSY:
      begin
        // Back-to-back: ack and new grant keep the cycle open
        if (wb_ack_i && !gnt_o)
          state_d = wb_pkg::WB_IDLE;
      end
      default: state_d = wb_pkg::WB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= wb_pkg::WB_IDLE;
    else
      state_q <= state_d;
  end

  // Address held stable until ack
  always_ff @(posedge clk)
  begin
    if (gnt_o)
      adr_q <= line_adr;
  end

endmodule

//--- design/prefetch_l0_buffer.sv
`timescale 1ns/1ns

module prefetch_l0_buffer #(
  parameter int LINE_WIDTH = 128
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    branch_i,
  input  logic                    ready_i,
  input  logic [31:0]             addr_i,      // Branch target

  output logic                    valid_o,
  output fetch_pkg::instr_word_t  rdata_o,
  output logic [31:0]             addr_o,

  output logic                    unaligned_valid_o,
  output fetch_pkg::instr_word_t  unaligned_rdata_o,

  // Line request port towards the bus master
  output logic                    instr_req_o,
  output wb_pkg::line_addr_t      instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [LINE_WIDTH-1:0]   instr_rdata_i,

  output logic                    busy_o
);

  localparam int NUM_WORDS  = LINE_WIDTH / 32;
  localparam int LINE_BYTES = LINE_WIDTH / 8;

  fetch_pkg::l0_state_e  state_q, state_d;
  wb_pkg::line_addr_t    line_addr_q;          // Line being served or fetched
  logic [1:0]            ptr_q, ptr_d;         // Word within the line
  logic                  next_line;            // Step line_addr_q to next line
  logic                  clear_buf;

  fetch_pkg::instr_word_t [NUM_WORDS-1:0] line_in;   // Arriving line, word view
  fetch_pkg::instr_word_t [NUM_WORDS-1:0] line_q;    // Stored line
  fetch_pkg::instr_word_t [NUM_WORDS-1:0] cur_line;  // Whichever one is served
  logic                  line_valid_q;
  logic [15:0]           prev_half_q;          // Upper half of previous line's last word
  logic                  prev_valid_q;

  logic                  serving_live;
  logic                  word_ok;
  logic [15:0]           low_half;
  logic                  low_ok;

  wb_pkg::line_addr_t    branch_line;
  wb_pkg::line_addr_t    seq_line;

  assign line_in     = instr_rdata_i;
  assign branch_line = {addr_i[31:4], 4'b0000};
  assign seq_line    = line_addr_q + LINE_BYTES;
  assign busy_o      = (state_q != fetch_pkg::EMPTY);

  ////////////////////////////////////////////////////////////////////////////
  // Word and halfword-straddling views
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    serving_live = (state_q == fetch_pkg::WAIT_RVALID);  // Bypass in rvalid cycle
    cur_line     = serving_live ? line_in : line_q;
    word_ok      = serving_live ? instr_rvalid_i : (state_q == fetch_pkg::VALID_L0);

    if (ptr_q == 2'd0)
    begin
      // Lower half comes from the previous line
      // While live, that line is still the stored one
      low_half = serving_live ? line_q[NUM_WORDS-1][31:16] : prev_half_q;
      low_ok   = serving_live ? line_valid_q : prev_valid_q;
    end
    else
    begin
      low_half = cur_line[ptr_q - 2'd1][31:16];
      low_ok   = 1'b1;
    end

    rdata_o           = cur_line[ptr_q];
    addr_o            = line_addr_q + {28'd0, ptr_q, 2'b00};
    valid_o           = word_ok & ~branch_i;          // Nothing stale during a branch
    unaligned_rdata_o = {cur_line[ptr_q][15:0], low_half};
    unaligned_valid_o = word_ok & low_ok & ~branch_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    ptr_d        = ptr_q;
    instr_req_o  = 1'b0;
    instr_addr_o = branch_line;
    next_line    = 1'b0;
    clear_buf    = 1'b0;

    case (state_q)
      fetch_pkg::EMPTY:
      begin
        instr_req_o = branch_i;  // First fetch starts at the target
      end

      fetch_pkg::WAIT_GNT:
      begin
        instr_req_o = 1'b1;
        if (!branch_i)
          instr_addr_o = line_addr_q;  // Already points at the wanted line
      end

      fetch_pkg::WAIT_RVALID:
      begin
        if (branch_i)
        begin
          if (instr_rvalid_i)
            instr_req_o = 1'b1;          // Bus free now, go to target
          else
            state_d = fetch_pkg::WAIT_ABORTED;
        end
        else if (instr_rvalid_i)
        begin
          state_d = fetch_pkg::VALID_L0;
          if (ready_i)
          begin
            if (&ptr_q)
            begin
              // Last word taken at once, prefetch next line
              instr_req_o  = 1'b1;
              instr_addr_o = seq_line;
              next_line    = 1'b1;
              ptr_d        = 2'd0;
            end
            else
            begin
              ptr_d = ptr_q + 2'd1;
            end
          end
        end
      end

      fetch_pkg::VALID_L0:
      begin
        if (branch_i)
          instr_req_o = 1'b1;
        else if (ready_i)
        begin
          if (&ptr_q)
          begin
            instr_req_o  = 1'b1;  // Line used up
            instr_addr_o = seq_line;
            next_line    = 1'b1;
            ptr_d        = 2'd0;
          end
          else
          begin
            ptr_d = ptr_q + 2'd1;
          end
        end
      end

      fetch_pkg::WAIT_ABORTED:
      begin
        clear_buf = 1'b1;  // Stale line must not land
        if (instr_rvalid_i)
        begin
          instr_req_o = 1'b1;
          if (!branch_i)
            instr_addr_o = line_addr_q;
        end
      end

      default:
      begin
        state_d   = fetch_pkg::EMPTY;
        clear_buf = 1'b1;
      end
    endcase

    // Every request ends up waiting for grant or data
    if (instr_req_o)
      state_d = instr_gnt_i ? fetch_pkg::WAIT_RVALID : fetch_pkg::WAIT_GNT;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= fetch_pkg::EMPTY;
      line_addr_q <= '0;
      ptr_q       <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (branch_i)
      begin
        line_addr_q <= branch_line;
        ptr_q       <= addr_i[3:2];  // Start at target word
      end
      else
      begin
        if (next_line)
          line_addr_q <= seq_line;
        ptr_q <= ptr_d;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      line_valid_q <= 1'b0;
      prev_valid_q <= 1'b0;
    end
    else if (branch_i || clear_buf)
    begin
      line_valid_q <= 1'b0;
      prev_valid_q <= 1'b0;
    end
    else if (instr_rvalid_i)
    begin
      line_valid_q <= 1'b1;
      prev_valid_q <= line_valid_q;  // Old line becomes the previous one
    end
  end

  always_ff @(posedge clk)
  begin
    if (instr_rvalid_i && !branch_i && !clear_buf)
    begin
      line_q <= line_in;
      if (line_valid_q)
        prev_half_q <= line_q[NUM_WORDS-1][31:16];
    end
  end

endmodule

//--- design/instr_aligner.sv
`timescale 1ns/1ns

module instr_aligner (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    branch_i,
  input  logic [31:0]             branch_addr_i,

  // Word stream from the L0 buffer
  input  logic                    valid_i,
  input  fetch_pkg::instr_word_t  rdata_i,
  input  logic [31:0]             addr_i,
  input  logic                    unaligned_valid_i,
  input  fetch_pkg::instr_word_t  unaligned_rdata_i,
  output logic                    ready_o,

  // Instruction stream to the next stage
  output logic                    instr_valid_o,
  output fetch_pkg::instr_word_t  instr_rdata_o,
  output logic [31:0]             instr_addr_o,
  output logic                    instr_compressed_o,
  input  logic                    instr_ready_i
);

  fetch_pkg::align_state_e state_q, state_d;
  logic                    take;  // Word available and downstream ready

  assign take = valid_i & instr_ready_i;

  always_comb
  begin
    state_d            = state_q;
    ready_o            = 1'b0;
    instr_valid_o      = 1'b0;
    instr_rdata_o      = rdata_i;
    instr_addr_o       = addr_i;
    instr_compressed_o = 1'b0;

    case (state_q)
      fetch_pkg::ALIGNED:
      begin
        instr_valid_o = valid_i;
        if (rdata_i[1:0] == 2'b11)
        begin
          ready_o = take;  // Full word, consume it
        end
        else
        begin
          instr_rdata_o      = {16'h0000, rdata_i[15:0]};
          instr_compressed_o = 1'b1;
          if (take)
            state_d = fetch_pkg::HALF;  // Same word, upper half next
        end
      end

      fetch_pkg::HALF:
      begin
        ready_o = take;  // Upper half always finishes the word
        if (rdata_i[17:16] != 2'b11)
        begin
          instr_valid_o      = valid_i;
          instr_rdata_o      = {16'h0000, rdata_i[31:16]};
          instr_addr_o       = addr_i + 32'd2;
          instr_compressed_o = 1'b1;
          if (take)
            state_d = fetch_pkg::ALIGNED;
        end
        else if (take)
        begin
          state_d = fetch_pkg::STRADDLE;  // Start of 32-bit instr, nothing emitted
        end
      end

      fetch_pkg::STRADDLE:
      begin
        // Buffer glues the upper half in, word stays in place
        instr_valid_o = unaligned_valid_i;
        instr_rdata_o = unaligned_rdata_i;
        instr_addr_o  = addr_i - 32'd2;
        if (unaligned_valid_i && instr_ready_i)
          state_d = fetch_pkg::HALF;
      end

      default: state_d = fetch_pkg::ALIGNED;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= fetch_pkg::ALIGNED;
    else if (branch_i)
      state_q <= branch_addr_i[1] ? fetch_pkg::HALF : fetch_pkg::ALIGNED;  // Target parity
    else
      state_q <= state_d;
  end

endmodule

//--- design/prefetch_top.sv
`timescale 1ns/1ns

module prefetch_top #(
  parameter int LINE_WIDTH = 128
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    branch_i,
  input  logic [31:0]             branch_addr_i,

  output logic                    instr_valid_o,
  output fetch_pkg::instr_word_t  instr_rdata_o,
  output logic [31:0]             instr_addr_o,
  output logic                    instr_compressed_o,
  input  logic                    instr_ready_i,

  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output wb_pkg::line_addr_t      wb_adr_o,
  input  logic [LINE_WIDTH-1:0]   wb_dat_i,
  input  logic                    wb_ack_i,

  output logic                    busy_o
);

  // Buffer to master
  logic                    line_req;
  wb_pkg::line_addr_t      line_addr;
  logic                    line_gnt;
  logic                    line_rvalid;
  logic [LINE_WIDTH-1:0]   line_rdata;

  // Buffer to aligner
  logic                    fetch_valid;
  fetch_pkg::instr_word_t  fetch_rdata;
  logic [31:0]             fetch_addr;
  logic                    fetch_unaligned_valid;
  fetch_pkg::instr_word_t  fetch_unaligned_rdata;
  logic                    fetch_ready;

  wb_line_master #(
    .LINE_WIDTH (LINE_WIDTH)
  ) i_wb_line_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (line_req),
    .addr_i   (line_addr),
    .gnt_o    (line_gnt),
    .rvalid_o (line_rvalid),
    .rdata_o  (line_rdata),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i)
  );

  prefetch_l0_buffer #(
    .LINE_WIDTH (LINE_WIDTH)
  ) i_prefetch_l0_buffer (
    .clk               (clk),
    .rst_n             (rst_n),
    .branch_i          (branch_i),
    .ready_i           (fetch_ready),
    .addr_i            (branch_addr_i),
    .valid_o           (fetch_valid),
    .rdata_o           (fetch_rdata),
    .addr_o            (fetch_addr),
    .unaligned_valid_o (fetch_unaligned_valid),
    .unaligned_rdata_o (fetch_unaligned_rdata),
    .instr_req_o       (line_req),
    .instr_addr_o      (line_addr),
    .instr_gnt_i       (line_gnt),
    .instr_rvalid_i    (line_rvalid),
    .instr_rdata_i     (line_rdata),
    .busy_o            (busy_o)
  );

  instr_aligner i_instr_aligner (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch_i),
    .branch_addr_i      (branch_addr_i),
    .valid_i            (fetch_valid),
    .rdata_i            (fetch_rdata),
    .addr_i             (fetch_addr),
    .unaligned_valid_i  (fetch_unaligned_valid),
    .unaligned_rdata_i  (fetch_unaligned_rdata),
    .ready_o            (fetch_ready),
    .instr_valid_o      (instr_valid_o),
    .instr_rdata_o      (instr_rdata_o),
    .instr_addr_o       (instr_addr_o),
    .instr_compressed_o (instr_compressed_o),
    .instr_ready_i      (instr_ready_i)
  );

endmodule

//--- verification/wb_instr_mem.sv
`timescale 1ns/1ns

module wb_instr_mem #(
  parameter int LINE_WIDTH = 128,
  parameter int DEPTH      = 64    // 32-bit words
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Wishbone classic slave, read only
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic [31:0]            wb_adr_i,
  output logic [LINE_WIDTH-1:0]  wb_dat_o,
  output logic                   wb_ack_o,

  input  logic [1:0]             delay_i     // Extra wait cycles before ack
);

  localparam int NUM_WORDS = LINE_WIDTH / 32;

  logic [31:0] mem [DEPTH];   // Loaded from outside before reset release
  logic [1:0]  wait_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ack_o <= 1'b0;
      wait_q   <= '0;
    end
    else if (wb_ack_o)
    begin
      wb_ack_o <= 1'b0;  // Single-cycle ack, next transfer starts fresh
      wait_q   <= '0;
    end
    else if (wb_cyc_i && wb_stb_i)
    begin
      if (wait_q >= delay_i)
      begin
        wb_ack_o <= 1'b1;
        for (int w = 0; w < NUM_WORDS; w++)
          wb_dat_o[32*w +: 32] <= mem[(int'(wb_adr_i[31:2]) + w) % DEPTH];  // Lowest word in LSBs
      end
      else
      begin
        wait_q <= wait_q + 2'd1;
      end
    end
  end

endmodule

//--- verification/tb_prefetch.sv
`timescale 1ns/1ns

module tb_prefetch;

  localparam int LINE_WIDTH       = 128;
  localparam int MEM_WORDS        = 64;
  localparam int CLK_PERIOD       = 4;
  localparam int CYCLES_PER_INSTR = 40;   // Generous budget per expected instr

  logic                    clk;
  logic                    rst_n;
  logic                    branch;
  logic [31:0]             branch_addr;
  logic                    instr_valid;
  fetch_pkg::instr_word_t  instr_rdata;
  logic [31:0]             instr_addr;
  logic                    instr_compressed;
  logic                    instr_ready;
  logic                    wb_cyc;
  logic                    wb_stb;
  wb_pkg::line_addr_t      wb_adr;
  logic [LINE_WIDTH-1:0]   wb_dat;
  logic                    wb_ack;
  logic                    busy;
  logic [1:0]              ack_delay;

  logic [31:0]             rnd;
  int                      total_instr;
  logic                    vectors_loaded;

  // Records and expected instruction stream
  logic [31:0]             rec_addr [$];
  int                      rec_cnt [$];
  fetch_pkg::instr_word_t  exp_addr [$];
  fetch_pkg::instr_word_t  exp_data [$];
  logic                    exp_comp [$];

  prefetch_top #(
    .LINE_WIDTH (LINE_WIDTH)
  ) i_prefetch_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch),
    .branch_addr_i      (branch_addr),
    .instr_valid_o      (instr_valid),
    .instr_rdata_o      (instr_rdata),
    .instr_addr_o       (instr_addr),
    .instr_compressed_o (instr_compressed),
    .instr_ready_i      (instr_ready),
    .wb_cyc_o           (wb_cyc),
    .wb_stb_o           (wb_stb),
    .wb_adr_o           (wb_adr),
    .wb_dat_i           (wb_dat),
    .wb_ack_i           (wb_ack),
    .busy_o             (busy)
  );

  wb_instr_mem #(
    .LINE_WIDTH (LINE_WIDTH),
    .DEPTH      (MEM_WORDS)
  ) i_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_adr_i (wb_adr),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack),
    .delay_i  (ack_delay)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input fetch_pkg::instr_word_t exp,
                            input fetch_pkg::instr_word_t act);
    if (act !== exp)
    begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic read_vectors();
    int          fd;
    int          rc;
    int          cnt;
    string       line;
    logic [31:0] word;
    logic [31:0] baddr;
    logic [31:0] a;
    logic [31:0] d;
    logic        c;
    fd = $fopen("verification/prefetch_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file");
      stop_run();
    end
    rc = $fgets(line, fd);  // Two column description lines
    rc = $fgets(line, fd);
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      rc = $fscanf(fd, "%h", word);
      if (rc != 1)
      begin
        $display("Vector file ends inside the memory image");
        stop_run();
      end
      i_mem.mem[i] = word;
    end
    while ($fscanf(fd, "%h %d", baddr, cnt) == 2)
    begin
      rec_addr.push_back(baddr);
      rec_cnt.push_back(cnt);
      for (int k = 0; k < cnt; k++)
      begin
        rc = $fscanf(fd, "%h %h %h", a, d, c);
        if (rc != 3)
        begin
          $display("Vector file has a truncated instruction record");
          stop_run();
        end
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_comp.push_back(c);
      end
    end
    $fclose(fd);
    total_instr = exp_addr.size();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    wait (vectors_loaded);
    #(total_instr * CYCLES_PER_INSTR * CLK_PERIOD);
    $display("Timeout: the fetch stream stalled before all instructions arrived");
    stop_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checking
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int idx;
    int got;
    string tag;
    clk            = 1'b0;
    rst_n          = 1'b0;
    branch         = 1'b0;
    branch_addr    = '0;
    instr_ready    = 1'b0;
    ack_delay      = '0;
    rnd            = 32'd94541;
    total_instr    = 0;
    vectors_loaded = 1'b0;
    idx            = 0;

    read_vectors();
    vectors_loaded = 1'b1;

    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    // Idle after reset, nothing fetched yet
    @(negedge clk);
    check_flag("reset wb_cyc", 1'b0, wb_cyc);
    check_flag("reset wb_stb", 1'b0, wb_stb);
    check_flag("reset instr_valid", 1'b0, instr_valid);
    check_flag("reset busy", 1'b0, busy);
    @(posedge clk);
    #1;

    for (int r = 0; r < rec_addr.size(); r++)
    begin
      branch      = 1'b1;           // Single-cycle pulse
      branch_addr = rec_addr[r];
      instr_ready = 1'b0;
      @(posedge clk);
      #1 branch = 1'b0;
      got = 0;
      while (got < rec_cnt[r])
      begin
        rnd         = xorshift(rnd);
        instr_ready = (rnd[1:0] != 2'b00);  // Stall about one cycle in four
        ack_delay   = rnd[3:2];
        @(negedge clk);             // Outputs settled mid-cycle
        if (instr_valid && instr_ready)
        begin
          tag = $sformatf("branch %h instr %0d", rec_addr[r], got);
          check_word({tag, " addr"}, exp_addr[idx], instr_addr);
          check_word({tag, " data"}, exp_data[idx], instr_rdata);
          check_flag({tag, " compressed"}, exp_comp[idx], instr_compressed);
          got++;
          idx++;
        end
        @(posedge clk);
        #1;
      end
      instr_ready = 1'b0;
    end

    $display("Everything OK");
    $finish;
  end

endmodule

//--- verification/prefetch_vectors.txt
# Memory image: 16 rows of 4 hex words, one 128-bit line per row, lowest address first
# Records: branch_addr count, then count triples of instr_addr instr_word compressed
10000013 10000113 10000213 10000313
10000413 10000513 10000613 10000713
10000813 10000913 10000a13 10000b13
10000c13 10000d13 10000e13 10000f13
42024101 53001303 15034401 16035500
47025600 19034801 4a015900 5b001b03
1d034c02 4e015d00 5f001f03 21034001
43026100 63002303 45024401 66002603
20000013 20000113 20000213 20000313
20000413 20000513 20000613 20000713
20000813 20000913 20000a13 20000b13
20000c13 20000d13 20000e13 20000f13
20001013 20001113 20001213 20001313
20001413 20001513 20001613 20001713
20001813 20001913 20001a13 20001b13
20001c13 20001d13 20001e13 20001f13
00000000 16
00 10000013 0  04 10000113 0  08 10000213 0  0c 10000313 0
10 10000413 0  14 10000513 0  18 10000613 0  1c 10000713 0
20 10000813 0  24 10000913 0  28 10000a13 0  2c 10000b13 0
30 10000c13 0  34 10000d13 0  38 10000e13 0  3c 10000f13 0
00000040 22
40 00004101 1  42 00004202 1  44 53001303 0  48 00004401 1
4a 55001503 0  4e 56001603 0  52 00004702 1  54 00004801 1
56 59001903 0  5a 00004a01 1  5c 5b001b03 0  60 00004c02 1
62 5d001d03 0  66 00004e01 1  68 5f001f03 0  6c 00004001 1
6e 61002103 0  72 00004302 1  74 63002303 0  78 00004401 1
7a 00004502 1  7c 66002603 0
0000004a 4
4a 55001503 0  4e 56001603 0  52 00004702 1  54 00004801 1
0000006e 3
6e 61002103 0  72 00004302 1  74 63002303 0
00000084 6
84 20000113 0  88 20000213 0  8c 20000313 0  90 20000413 0
94 20000513 0  98 20000613 0
0000000c 2
0c 10000313 0  10 10000413 0

//--- filelist.f
design/fetch_pkg.sv
design/wb_pkg.sv
design/wb_line_master.sv
design/prefetch_l0_buffer.sv
design/instr_aligner.sv
design/prefetch_top.sv
verification/wb_instr_mem.sv
verification/tb_prefetch.sv

//--- Bender.yml
package:
  name: prefetch_l0

sources:
  - files:
      - design/fetch_pkg.sv
      - design/wb_pkg.sv
      - design/wb_line_master.sv
      - design/prefetch_l0_buffer.sv
      - design/instr_aligner.sv
      - design/prefetch_top.sv
  - target: test
    files:
      - verification/wb_instr_mem.sv
      - verification/tb_prefetch.sv
